// ==== design/gty_rx_pkg.sv ====
package gty_rx_pkg;

  ////////////////////////////////////////
  // Sync header codes
  ////////////////////////////////////////

  // 64b/66b data block
  localparam logic [1:0] HDR_DATA = 2'b01;
  // 64b/66b control block
  localparam logic [1:0] HDR_CTRL = 2'b10;

  // Length of the x^58 + x^39 + 1 descrambler state
  localparam int SCR_WIDTH = 58;

  ////////////////////////////////////////
  // Lane data types
  ////////////////////////////////////////

  // One word from the transceiver gearbox, 36 bits
  typedef struct packed {
    logic [31:0] data;
    logic        data_valid;
    // Header is only meaningful with header_valid
    logic [1:0]  header;
    logic        header_valid;
  } gb_word_t;

  // One received 66-bit block plus the decoded control flag, 67 bits
  typedef struct packed {
    logic [1:0]  header;
    // Set for HDR_CTRL blocks
    logic        ctrl;
    // Descrambled payload, first word in the low half
    logic [63:0] payload;
  } rx_block_t;

  // Per-lane status word, 25 bits
  typedef struct packed {
    logic        locked;
    // Both counters stop at all ones
    logic [7:0]  slip_count;
    logic [15:0] bad_hdr_count;
  } lane_stat_t;

endpackage

// ==== design/block_lock.sv ====
`timescale 1ns/1ps

module block_lock #(
  parameter int LOCK_COUNT = 16,
  parameter int BAD_LIMIT  = 4,
  parameter int SLIP_WAIT  = 4
) (
  input  logic                 clkout,
  input  logic                 rst,
  input  gty_rx_pkg::gb_word_t rx_word,
  output logic                 locked,
  output logic                 slip,
  output logic                 bad_hdr
);

  localparam int GOOD_W = (LOCK_COUNT > 1) ? $clog2(LOCK_COUNT) : 1;
  localparam int BAD_W  = (BAD_LIMIT > 1) ? $clog2(BAD_LIMIT) : 1;
  localparam int WAIT_W = (SLIP_WAIT > 1) ? $clog2(SLIP_WAIT) : 1;

  typedef enum logic [1:0] {
    ST_HUNT,
    ST_WAIT,
    ST_LOCKED
  } lock_state_t;

  lock_state_t       state;
  logic [GOOD_W-1:0] good_cnt;
  logic [BAD_W-1:0]  bad_cnt;
  logic [WAIT_W-1:0] wait_cnt;
  logic              hdr_seen;
  logic              hdr_ok;

  // Only the first word of a block carries a header
  assign hdr_seen = rx_word.header_valid && rx_word.data_valid;
  assign hdr_ok   = (rx_word.header == gty_rx_pkg::HDR_DATA) ||
                    (rx_word.header == gty_rx_pkg::HDR_CTRL);

  assign locked = (state == ST_LOCKED);

  always_ff @(posedge clkout) begin
    if (rst) begin
      state    <= ST_HUNT;
      good_cnt <= '0;
      bad_cnt  <= '0;
      wait_cnt <= '0;
      slip     <= 1'b0;
      bad_hdr  <= 1'b0;
    end else begin
      slip    <= 1'b0;
      bad_hdr <= 1'b0;
      if (hdr_seen) begin
        case (state)
          ST_HUNT: begin
            if (hdr_ok) begin
              if (good_cnt == GOOD_W'(LOCK_COUNT - 1)) begin
                state    <= ST_LOCKED;
                good_cnt <= '0;
                bad_cnt  <= '0;
              end else begin
                good_cnt <= good_cnt + 1'b1;
              end
            end else begin
              // Bad alignment, ask the gearbox to shift by one bit
              good_cnt <= '0;
              slip     <= 1'b1;
              wait_cnt <= '0;
              state    <= (SLIP_WAIT == 0) ? ST_HUNT : ST_WAIT;
            end
          end
          ST_WAIT: begin
            // Headers right after a slip are not yet realigned
            if (wait_cnt == WAIT_W'(SLIP_WAIT - 1)) begin
              state <= ST_HUNT;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end
          ST_LOCKED: begin
            if (hdr_ok) begin
              bad_cnt <= '0;
            end else begin
              bad_hdr <= 1'b1;
              if (bad_cnt == BAD_W'(BAD_LIMIT - 1)) begin
                // Drop lock but keep current alignment
                state    <= ST_HUNT;
                bad_cnt  <= '0;
                good_cnt <= '0;
              end else begin
                bad_cnt <= bad_cnt + 1'b1;
              end
            end
          end
          default: state <= ST_HUNT;
        endcase
      end
    end
  end

endmodule

// ==== design/descrambler_58.sv ====
`timescale 1ns/1ps

module descrambler_58 (
  input  logic        clkout,
  input  logic        rst,
  input  logic [31:0] din,
  input  logic        din_valid,
  output logic [31:0] dout,
  output logic        dout_valid
);

  // Tap positions of x^58 + x^39 + 1
  localparam int TAP_A = 39;
  localparam int TAP_B = gty_rx_pkg::SCR_WIDTH;

  // Bit 0 holds the most recently received line bit
  logic [gty_rx_pkg::SCR_WIDTH-1:0] scr_state;
  logic [gty_rx_pkg::SCR_WIDTH-1:0] scr_next;
  logic [31:0]                      dout_next;

  ////////////////////////////////////////
  // Bit-serial unroll, bit 0 first
  ////////////////////////////////////////

  always_comb begin
    scr_next = scr_state;
    for (int i = 0; i < 32; i++) begin
      dout_next[i] = din[i] ^ scr_next[TAP_A-1] ^ scr_next[TAP_B-1];
      // Self-synchronous, the state follows the line bits
      scr_next = {scr_next[gty_rx_pkg::SCR_WIDTH-2:0], din[i]};
    end
  end

  always_ff @(posedge clkout) begin
    if (rst) begin
      scr_state  <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= din_valid;
      if (din_valid) begin
        scr_state <= scr_next;
      end
    end
  end

  always_ff @(posedge clkout) begin
    if (din_valid) begin
      dout <= dout_next;
    end
  end

endmodule

// ==== design/block_assembler.sv ====
`timescale 1ns/1ps

module block_assembler (
  input  logic                  clkout,
  input  logic                  rst,
  input  logic [31:0]           word,
  input  logic                  word_valid,
  input  logic [1:0]            header,
  input  logic                  first,
  input  logic                  locked,
  output gty_rx_pkg::rx_block_t block,
  output logic                  block_valid
);

  logic [31:0] low_half;
  logic [1:0]  hdr_hold;
  logic        have_low;
  logic        complete;

  // Second half arrives on the next valid word after a first one
  assign complete = word_valid && !first && have_low;

  ////////////////////////////////////////
  // Half-block tracking
  ////////////////////////////////////////

  always_ff @(posedge clkout) begin
    if (rst) begin
      have_low    <= 1'b0;
      block_valid <= 1'b0;
    end else begin
      block_valid <= complete && locked;
      if (word_valid) begin
        have_low <= first;
      end
    end
  end

  always_ff @(posedge clkout) begin
    if (word_valid && first) begin
      low_half <= word;
      hdr_hold <= header;
    end
  end

  ////////////////////////////////////////
  // Block output register
  ////////////////////////////////////////

  always_ff @(posedge clkout) begin
    if (complete) begin
      block.header  <= hdr_hold;
      block.ctrl    <= (hdr_hold == gty_rx_pkg::HDR_CTRL);
      block.payload <= {word, low_half};
    end
  end

endmodule

// ==== design/rx_lane.sv ====
`timescale 1ns/1ps

module rx_lane #(
  parameter int LOCK_COUNT = 16,
  parameter int BAD_LIMIT  = 4,
  parameter int SLIP_WAIT  = 4
) (
  input  logic                  clkout,
  input  logic                  rst,
  input  gty_rx_pkg::gb_word_t  rx_word,
  output logic                  slip,
  output gty_rx_pkg::rx_block_t block,
  output logic                  block_valid,
  output logic                  locked,
  output logic                  bad_hdr
);

  logic [31:0] desc_data;
  logic        desc_valid;
  logic [1:0]  hdr_d;
  logic        first_d;

  // Header alignment search
  block_lock #(
    .LOCK_COUNT (LOCK_COUNT),
    .BAD_LIMIT  (BAD_LIMIT),
    .SLIP_WAIT  (SLIP_WAIT)
  ) u_lock (
    .clkout  (clkout),
    .rst     (rst),
    .rx_word (rx_word),
    .locked  (locked),
    .slip    (slip),
    .bad_hdr (bad_hdr)
  );

  descrambler_58 u_descr (
    .clkout     (clkout),
    .rst        (rst),
    .din        (rx_word.data),
    .din_valid  (rx_word.data_valid),
    .dout       (desc_data),
    .dout_valid (desc_valid)
  );

  // Match header timing to the registered descrambler output
  always_ff @(posedge clkout) begin
    if (rst) begin
      first_d <= 1'b0;
    end else begin
      first_d <= rx_word.header_valid && rx_word.data_valid;
    end
  end

  always_ff @(posedge clkout) begin
    hdr_d <= rx_word.header;
  end

  block_assembler u_asm (
    .clkout      (clkout),
    .rst         (rst),
    .word        (desc_data),
    .word_valid  (desc_valid),
    .header      (hdr_d),
    .first       (first_d),
    .locked      (locked),
    .block       (block),
    .block_valid (block_valid)
  );

endmodule

// ==== design/lane_status.sv ====
`timescale 1ns/1ps

module lane_status (
  input  logic                   clkout,
  input  logic                   rst,
  input  logic                   locked,
  input  logic                   slip,
  input  logic                   bad_hdr,
  output gty_rx_pkg::lane_stat_t status
);

  logic slip_full;
  logic bad_full;

  // Saturation limits, counters hold at all ones
  assign slip_full = &status.slip_count;
  assign bad_full  = &status.bad_hdr_count;

  ////////////////////////////////////////
  // Registered status word
  ////////////////////////////////////////

  always_ff @(posedge clkout) begin
    if (rst) begin
      status <= '0;
    end else begin
      status.locked <= locked;

      // Gearbox slips issued while hunting
      if (slip && !slip_full) begin
        status.slip_count <= status.slip_count + 8'd1;
      end

      // Invalid headers seen while locked
      if (bad_hdr && !bad_full) begin
        status.bad_hdr_count <= status.bad_hdr_count + 16'd1;
      end
    end
  end

endmodule

// ==== design/gty_rx_top.sv ====
`timescale 1ns/1ps

module gty_rx_top #(
  parameter int NUM_LANES  = 12,
  parameter int LOCK_COUNT = 16,
  parameter int BAD_LIMIT  = 4,
  parameter int SLIP_WAIT  = 4
) (
  input  logic                                  clkout,
  input  logic                                  rst,
  input  gty_rx_pkg::gb_word_t  [NUM_LANES-1:0] rx_word,
  output logic                  [NUM_LANES-1:0] gearbox_slip,
  output gty_rx_pkg::rx_block_t [NUM_LANES-1:0] block,
  output logic                  [NUM_LANES-1:0] block_valid,
  output gty_rx_pkg::lane_stat_t [NUM_LANES-1:0] status
);

  logic [NUM_LANES-1:0] locked_w;
  logic [NUM_LANES-1:0] bad_hdr_w;

  ////////////////////////////////////////
  // Per-lane receive and status
  ////////////////////////////////////////

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane

    // Slip goes straight back to the gearbox
    rx_lane #(
      .LOCK_COUNT (LOCK_COUNT),
      .BAD_LIMIT  (BAD_LIMIT),
      .SLIP_WAIT  (SLIP_WAIT)
    ) u_lane (
      .clkout      (clkout),
      .rst         (rst),
      .rx_word     (rx_word[g]),
      .slip        (gearbox_slip[g]),
      .block       (block[g]),
      .block_valid (block_valid[g]),
      .locked      (locked_w[g]),
      .bad_hdr     (bad_hdr_w[g])
    );

    lane_status u_stat (
      .clkout  (clkout),
      .rst     (rst),
      .locked  (locked_w[g]),
      .slip    (gearbox_slip[g]),
      .bad_hdr (bad_hdr_w[g]),
      .status  (status[g])
    );

  end

endmodule

// ==== bench/gty_rx_props.sv ====
`timescale 1ns/1ps

module lane_props (
  input logic clkout,
  input logic rst,
  input logic slip,
  input logic locked,
  input logic block_valid,
  input logic din_valid,
  input logic dout_valid
);

  // Slip is a single-cycle pulse
  assert property (@(posedge clkout) disable iff (rst) slip |=> !slip)
    else $error("slip high in two consecutive cycles");

  assert property (@(posedge clkout) disable iff (rst) !(slip && locked))
    else $error("slip raised while locked");

  // Blocks only leave a locked lane
  assert property (@(posedge clkout) disable iff (rst) $rose(block_valid) |-> locked)
    else $error("block_valid rose while unlocked");

  ////////////////////////////////////////
  // Descrambler latency
  ////////////////////////////////////////

  assert property (@(posedge clkout) disable iff (rst) din_valid |=> dout_valid)
    else $error("dout_valid missing one cycle after din_valid");

  assert property (@(posedge clkout) disable iff (rst) !din_valid |=> !dout_valid)
    else $error("dout_valid without din_valid one cycle before");

endmodule

bind rx_lane lane_props u_props (
  .clkout      (clkout),
  .rst         (rst),
  .slip        (slip),
  .locked      (locked),
  .block_valid (block_valid),
  .din_valid   (rx_word.data_valid),
  .dout_valid  (desc_valid)
);

// ==== bench/gty_rx_tb.sv ====
`timescale 1ns/1ps

module gty_rx_tb;

  localparam int NUM_LANES  = 4;
  localparam int LOCK_COUNT = 16;
  localparam int BAD_LIMIT  = 4;
  localparam int SLIP_WAIT  = 4;
  localparam int LOCK_TIMEOUT  = 300;
  localparam int DRAIN_TIMEOUT = 60;

  // One stimulus row per lane
  typedef struct packed {
    logic [7:0]  slips;
    logic [7:0]  nblk;
    logic [7:0]  bad_pos;
    logic [7:0]  bad_len;
    logic [31:0] ctrl_mask;
  } row_t;

  logic                                          clkout;
  logic                                          rst;
  gty_rx_pkg::gb_word_t   [NUM_LANES-1:0]        rx_word;
  logic                   [NUM_LANES-1:0]        gearbox_slip;
  gty_rx_pkg::rx_block_t  [NUM_LANES-1:0]        block;
  logic                   [NUM_LANES-1:0]        block_valid;
  gty_rx_pkg::lane_stat_t [NUM_LANES-1:0]        status;

  row_t                  rows     [NUM_LANES];
  gty_rx_pkg::gb_word_t  nxt      [NUM_LANES];
  logic [57:0]           scr_st   [NUM_LANES];
  int                    rem      [NUM_LANES];
  logic                  saw_unlock [NUM_LANES];
  gty_rx_pkg::rx_block_t exp_q    [NUM_LANES][$];
  int                    errors;
  logic                  check_en;
  logic                  timed_out;

  gty_rx_top #(
    .NUM_LANES  (NUM_LANES),
    .LOCK_COUNT (LOCK_COUNT),
    .BAD_LIMIT  (BAD_LIMIT),
    .SLIP_WAIT  (SLIP_WAIT)
  ) uut (
    .clkout       (clkout),
    .rst          (rst),
    .rx_word      (rx_word),
    .gearbox_slip (gearbox_slip),
    .block        (block),
    .block_valid  (block_valid),
    .status       (status)
  );

  initial begin
    clkout = 1'b0;
    forever #2 clkout = ~clkout;
  end

  ////////////////////////////////////////
  // Checker and gearbox model
  ////////////////////////////////////////

  task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                           input string msg);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // Reference x^58 + x^39 + 1 scrambler working bit 0 first
  task automatic build_word(input int l, input logic [31:0] d, input logic hv,
                            input logic [1:0] hdr);
    logic [31:0] q;
    logic [57:0] st;
    st = scr_st[l];
    for (int i = 0; i < 32; i++) begin
      q[i] = d[i] ^ st[38] ^ st[57];
      st = {st[56:0], q[i]};
    end
    scr_st[l] = st;
    nxt[l].data         = q;
    nxt[l].data_valid   = 1'b1;
    nxt[l].header       = hv ? hdr : 2'b00;
    nxt[l].header_valid = hv;
  endtask

  task automatic idle_word(input int l);
    nxt[l] = '0;
  endtask

  // Drive one cycle and let the gearbox react to slip pulses
  task automatic apply_cycle();
    @(posedge clkout);
    #1;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (gearbox_slip[l] && rem[l] > 0) begin
        rem[l]--;
      end
      rx_word[l] = nxt[l];
    end
  endtask

  task automatic send_training_block();
    logic [1:0] hdr;
    for (int l = 0; l < NUM_LANES; l++) begin
      // Misaligned gearbox shows only 00 or 11
      if (rem[l] > 0) begin
        hdr = $urandom_range(1) ? 2'b11 : 2'b00;
      end else begin
        hdr = gty_rx_pkg::HDR_DATA;
      end
      build_word(l, $urandom, 1'b1, hdr);
    end
    apply_cycle();
    for (int l = 0; l < NUM_LANES; l++) begin
      build_word(l, $urandom, 1'b0, 2'b00);
    end
    apply_cycle();
    for (int l = 0; l < NUM_LANES; l++) begin
      idle_word(l);
    end
    apply_cycle();
  endtask

  task automatic send_data_block(input int k);
    logic [31:0] lo [NUM_LANES];
    logic [31:0] hi [NUM_LANES];
    logic [1:0]  hdr;
    logic        bad;
    logic        emit;
    int          drop_lo;
    gty_rx_pkg::rx_block_t eb;
    for (int l = 0; l < NUM_LANES; l++) begin
      lo[l] = $urandom;
      hi[l] = $urandom;
      if (k < int'(rows[l].nblk)) begin
        bad = (rows[l].bad_len != 0) && (k >= int'(rows[l].bad_pos)) &&
              (k < int'(rows[l].bad_pos) + int'(rows[l].bad_len));
        if (bad) begin
          hdr = 2'b11;
        end else begin
          hdr = rows[l].ctrl_mask[k] ? gty_rx_pkg::HDR_CTRL : gty_rx_pkg::HDR_DATA;
        end
        // Lock is lost on the last bad header and back on the last of LOCK_COUNT good ones
        drop_lo = int'(rows[l].bad_pos) + BAD_LIMIT - 1;
        emit = !((int'(rows[l].bad_len) == BAD_LIMIT) && (k >= drop_lo) &&
                 (k < drop_lo + LOCK_COUNT));
        if (emit) begin
          eb.header  = hdr;
          eb.ctrl    = !bad && rows[l].ctrl_mask[k];
          eb.payload = {hi[l], lo[l]};
          exp_q[l].push_back(eb);
        end
        build_word(l, lo[l], 1'b1, hdr);
      end else begin
        idle_word(l);
      end
    end
    apply_cycle();
    for (int l = 0; l < NUM_LANES; l++) begin
      if (k < int'(rows[l].nblk)) begin
        build_word(l, hi[l], 1'b0, 2'b00);
      end else begin
        idle_word(l);
      end
    end
    apply_cycle();
    for (int l = 0; l < NUM_LANES; l++) begin
      idle_word(l);
    end
    apply_cycle();
  endtask

  ////////////////////////////////////////
  // Block monitor
  ////////////////////////////////////////

  initial begin
    gty_rx_pkg::rx_block_t eb;
    forever begin
      @(posedge clkout);
      #3;
      if (check_en) begin
        for (int l = 0; l < NUM_LANES; l++) begin
          if (!status[l].locked) begin
            saw_unlock[l] = 1'b1;
          end
          if (block_valid[l]) begin
            if (exp_q[l].size() == 0) begin
              errors++;
              $display("Lane %0d delivered a block that was not expected at %0t ns",
                       l, $time);
            end else begin
              eb = exp_q[l].pop_front();
              check_val(block[l].header, eb.header, $sformatf("lane %0d header", l));
              check_val(block[l].ctrl, eb.ctrl, $sformatf("lane %0d ctrl", l));
              check_val(block[l].payload, eb.payload, $sformatf("lane %0d payload", l));
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int  n;
    int  max_blk;
    logic all_locked;
    logic all_empty;
    void'($urandom(32'h534c));
    errors    = 0;
    check_en  = 1'b0;
    timed_out = 1'b0;
    rst       = 1'b1;
    rx_word   = '0;
    // slips, blocks, bad position, bad run length, ctrl mask
    rows[0] = {8'd0, 8'd12, 8'd0, 8'd0, 32'h0000_0f0f};
    rows[1] = {8'd3, 8'd12, 8'd4, 8'd1, 32'h0000_0aa5};
    rows[2] = {8'd7, 8'd10, 8'd0, 8'd0, 32'h0000_0001};
    rows[3] = {8'd2, 8'd30, 8'd5, 8'd4, 32'h1234_0c03};
    max_blk = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      nxt[l]        = '0;
      scr_st[l]     = '0;
      rem[l]        = int'(rows[l].slips);
      saw_unlock[l] = 1'b0;
      if (int'(rows[l].nblk) > max_blk) begin
        max_blk = int'(rows[l].nblk);
      end
    end
    repeat (5) @(posedge clkout);
    #1;
    rst = 1'b0;

    // Hunt for block lock on every lane
    n = 0;
    all_locked = 1'b0;
    while (!all_locked && n < LOCK_TIMEOUT) begin
      send_training_block();
      n++;
      all_locked = 1'b1;
      for (int l = 0; l < NUM_LANES; l++) begin
        all_locked = all_locked && status[l].locked;
      end
    end
    if (!all_locked) begin
      errors++;
      timed_out = 1'b1;
      $display("Timed out waiting for block lock on all lanes");
    end

    if (!timed_out) begin
      repeat (4) apply_cycle();
      for (int l = 0; l < NUM_LANES; l++) begin
        check_val(status[l].slip_count, rows[l].slips,
                  $sformatf("lane %0d slip count at lock", l));
      end
      check_en = 1'b1;
      for (int k = 0; k < max_blk; k++) begin
        send_data_block(k);
      end

      // Drain until every expected block has arrived
      n = 0;
      all_empty = 1'b0;
      while (!all_empty && n < DRAIN_TIMEOUT) begin
        apply_cycle();
        n++;
        all_empty = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
          all_empty = all_empty && (exp_q[l].size() == 0);
        end
      end
      if (!all_empty) begin
        errors++;
        $display("Timed out waiting for the expected blocks to arrive");
      end
      repeat (8) apply_cycle();
      check_en = 1'b0;

      for (int l = 0; l < NUM_LANES; l++) begin
        check_val(status[l].locked, 1'b1, $sformatf("lane %0d locked at end", l));
        check_val(status[l].slip_count, rows[l].slips,
                  $sformatf("lane %0d slip count at end", l));
        check_val(status[l].bad_hdr_count, rows[l].bad_len,
                  $sformatf("lane %0d bad header count", l));
        check_val(saw_unlock[l], int'(rows[l].bad_len) == BAD_LIMIT,
                  $sformatf("lane %0d loss of lock seen", l));
      end
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== gty_rx_top.f ====
design/gty_rx_pkg.sv
design/block_lock.sv
design/descrambler_58.sv
design/block_assembler.sv
design/rx_lane.sv
design/lane_status.sv
design/gty_rx_top.sv
bench/gty_rx_props.sv
bench/gty_rx_tb.sv

// ==== Bender.yml ====
package:
  name: gty_rx

sources:
  - design/gty_rx_pkg.sv
  - design/block_lock.sv
  - design/descrambler_58.sv
  - design/block_assembler.sv
  - design/rx_lane.sv
  - design/lane_status.sv
  - design/gty_rx_top.sv
  - target: simulation
    files:
      - bench/gty_rx_props.sv
      - bench/gty_rx_tb.sv
